// File: verilog/comm_pkg.sv
`default_nettype none

package comm_pkg;

  localparam int DATA_W = 64;
  localparam int RAM_AW = 12;
  localparam int RAM_DEPTH = 1 << RAM_AW;
  localparam int LEN_W = 16;
  localparam int EXT_AW = 64;

  localparam int RAM_READ_LATENCY = 2;
  // room for the reads in flight plus two beats of slack
  localparam int STORE_QUEUE_DEPTH = RAM_READ_LATENCY + 2;
  localparam int STORE_PTR_W = $clog2(STORE_QUEUE_DEPTH);
  localparam int STORE_CNT_W = $clog2(STORE_QUEUE_DEPTH + 1);

  localparam logic [1:0] DIR_LOAD = 2'd1;
  localparam logic [1:0] DIR_STORE = 2'd2;

  typedef struct packed {
    logic       route_socket;
    logic [1:0] dir;
  } lsu_mode_t;

  typedef struct packed {
    logic [RAM_AW-1:0] ram_start_idx;
    logic [RAM_AW-1:0] ram_stride;
    logic [LEN_W-1:0]  len;
    logic [EXT_AW-1:0] ext_addr;
    lsu_mode_t         mode;
  } xfer_cfg_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              valid;
  } beat_t;

  typedef struct packed {
    logic              start;
    logic              store;
    logic [EXT_AW-1:0] ext_addr;
    logic [LEN_W-1:0]  len;
  } dma_cmd_t;

  typedef struct packed {
    logic              ce;
    logic              we;
    logic [RAM_AW-1:0] addr;
    logic [DATA_W-1:0] d;
  } ram_req_t;

endpackage

`default_nettype wire

// File: verilog/scratch_ram.sv
`timescale 1ns/1ns
`default_nettype none

module scratch_ram (
  input  logic                        clk,
  input  comm_pkg::ram_req_t          ram_req,
  output logic [comm_pkg::DATA_W-1:0] ram_q
);

  logic [comm_pkg::DATA_W-1:0] mem [comm_pkg::RAM_DEPTH];
  logic [comm_pkg::RAM_AW-1:0] rd_addr;

  always_ff @(posedge clk) begin
    if (ram_req.ce & ram_req.we)
      mem[ram_req.addr] <= ram_req.d;
    // address stage, then data stage
    if (ram_req.ce & ~ram_req.we)
      rd_addr <= ram_req.addr;
    ram_q <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: verilog/lsu_engine.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_engine (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        go,
  input  logic                        store,
  input  comm_pkg::xfer_cfg_t         cfg,
  input  comm_pkg::beat_t             lsu_in,
  output logic                        lsu_in_ready,
  output comm_pkg::beat_t             lsu_out,
  input  logic                        lsu_out_ready,
  output logic                        lsu_done,
  output comm_pkg::ram_req_t          ram_req,
  input  logic [comm_pkg::DATA_W-1:0] ram_q
);

  logic active, is_store;
  logic [comm_pkg::RAM_AW-1:0] addr, stride;
  logic [comm_pkg::LEN_W-1:0] rd_left, beat_left;
  logic [comm_pkg::RAM_READ_LATENCY-1:0] rd_tag;
  logic [comm_pkg::DATA_W-1:0] queue [comm_pkg::STORE_QUEUE_DEPTH];
  logic [comm_pkg::STORE_PTR_W-1:0] wr_ptr, rd_ptr;
  logic [comm_pkg::STORE_CNT_W-1:0] q_count, credit;
  logic load_fire, rd_issue, push, pop, last_beat;

  assign lsu_in_ready = active & ~is_store;
  assign load_fire = lsu_in_ready & lsu_in.valid;

  // credit covers reads in flight and beats already queued
  assign rd_issue = active & is_store & (rd_left != '0) &
                    (credit != comm_pkg::STORE_CNT_W'(comm_pkg::STORE_QUEUE_DEPTH));
  assign push = rd_tag[comm_pkg::RAM_READ_LATENCY-1];
  assign pop = (q_count != '0) & lsu_out_ready;
  assign last_beat = (beat_left == 1) & (load_fire | pop);

  always_comb begin
    ram_req.ce = load_fire | rd_issue;
    ram_req.we = load_fire;
    ram_req.addr = addr;
    ram_req.d = lsu_in.data;
    lsu_out.data = queue[rd_ptr];
    lsu_out.valid = q_count != '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      is_store <= 1'b0;
      lsu_done <= 1'b0;
      rd_left <= '0;
      beat_left <= '0;
      rd_tag <= '0;
      credit <= '0;
      q_count <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      lsu_done <= 1'b0;
      rd_tag <= {rd_tag[comm_pkg::RAM_READ_LATENCY-2:0], rd_issue};
      if (go) begin
        // zero-length transfer finishes right away
        active <= cfg.len != '0;
        lsu_done <= cfg.len == '0;
        is_store <= store;
        rd_left <= cfg.len;
        beat_left <= cfg.len;
      end else begin
        if (last_beat) begin
          active <= 1'b0;
          lsu_done <= 1'b1;
        end
        if (rd_issue)
          rd_left <= rd_left - 1'b1;
        if (load_fire | pop)
          beat_left <= beat_left - 1'b1;
      end
      case ({rd_issue, pop})
        2'b10: credit <= credit + 1'b1;
        2'b01: credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
      case ({push, pop})
        2'b10: q_count <= q_count + 1'b1;
        2'b01: q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // address walk shared by load writes and store reads
  always_ff @(posedge clk) begin
    if (go) begin
      addr <= cfg.ram_start_idx;
      stride <= cfg.ram_stride;
    end else if (load_fire | rd_issue) begin
      addr <= addr + stride;
    end
    if (push)
      queue[wr_ptr] <= ram_q;
  end

endmodule

`default_nettype wire

// File: verilog/xfer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module xfer_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  comm_pkg::xfer_cfg_t         cfg,
  input  logic [comm_pkg::EXT_AW-1:0] ext_mem_offset,
  input  logic                        dma_done,
  input  logic                        dma_write_idle,
  output logic                        done,
  output comm_pkg::dma_cmd_t          dma_cmd,
  output logic                        go,
  output logic                        store,
  input  comm_pkg::beat_t             dma_in,
  output logic                        dma_in_ready,
  output comm_pkg::beat_t             dma_out,
  input  logic                        dma_out_ready,
  input  comm_pkg::beat_t             sock_in,
  output logic                        sock_in_ready,
  output comm_pkg::beat_t             sock_out,
  input  logic                        sock_out_ready,
  output comm_pkg::beat_t             lsu_in,
  input  logic                        lsu_in_ready,
  input  comm_pkg::beat_t             lsu_out,
  output logic                        lsu_out_ready,
  input  logic                        lsu_done
);

  logic load_dma_run, load_sock_run, store_dma_run, store_sock_run;
  logic want_load, want_store, start_ok;
  logic dma_done_q, lsu_fin_q, dma_store_done;
  logic cmd_start, cmd_store;
  logic [comm_pkg::EXT_AW-1:0] cmd_addr;
  logic [comm_pkg::LEN_W-1:0] cmd_len;

  assign want_load = cfg.mode.dir == comm_pkg::DIR_LOAD;
  assign want_store = cfg.mode.dir == comm_pkg::DIR_STORE;
  assign start_ok = start & (want_load | want_store) &
                    ~(load_dma_run | load_sock_run | store_dma_run | store_sock_run);

  // dma store ends only once the engine, the dma and its write side are all through
  assign dma_store_done = store_dma_run & (lsu_fin_q | lsu_done) & dma_done_q & dma_write_idle;
  assign done = (lsu_done & (load_dma_run | load_sock_run | store_sock_run)) | dma_store_done;
  assign store = store_dma_run | store_sock_run;

  always_ff @(posedge clk) begin
    if (reset) begin
      load_dma_run <= 1'b0;
      load_sock_run <= 1'b0;
      store_dma_run <= 1'b0;
      store_sock_run <= 1'b0;
      dma_done_q <= 1'b0;
      lsu_fin_q <= 1'b0;
      go <= 1'b0;
      cmd_start <= 1'b0;
    end else begin
      go <= start_ok;
      cmd_start <= start_ok & ~cfg.mode.route_socket;
      if (start_ok) begin
        load_dma_run <= want_load & ~cfg.mode.route_socket;
        load_sock_run <= want_load & cfg.mode.route_socket;
        store_dma_run <= want_store & ~cfg.mode.route_socket;
        store_sock_run <= want_store & cfg.mode.route_socket;
      end else if (lsu_done) begin
        load_dma_run <= 1'b0;
        load_sock_run <= 1'b0;
        store_sock_run <= 1'b0;
      end
      if (lsu_done & store_dma_run)
        lsu_fin_q <= 1'b1;
      if (dma_done & store_dma_run)
        dma_done_q <= 1'b1;
      if (dma_store_done) begin
        store_dma_run <= 1'b0;
        lsu_fin_q <= 1'b0;
        dma_done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      cmd_store <= want_store;
      cmd_addr <= cfg.ext_addr + ext_mem_offset;
      cmd_len <= cfg.len;
    end
  end

  always_comb begin
    dma_cmd = '{start: cmd_start, store: cmd_store, ext_addr: cmd_addr, len: cmd_len};
    lsu_in.data = load_dma_run ? dma_in.data : sock_in.data;
    lsu_in.valid = (load_dma_run & dma_in.valid) | (load_sock_run & sock_in.valid);
    dma_in_ready = load_dma_run & lsu_in_ready;
    sock_in_ready = load_sock_run & lsu_in_ready;
    dma_out.data = lsu_out.data;
    dma_out.valid = store_dma_run & lsu_out.valid;
    sock_out.data = lsu_out.data;
    sock_out.valid = store_sock_run & lsu_out.valid;
    lsu_out_ready = (store_dma_run & dma_out_ready) | (store_sock_run & sock_out_ready);
  end

endmodule

`default_nettype wire

// File: verilog/comm_block.sv
`timescale 1ns/1ns
`default_nettype none

module comm_block (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  comm_pkg::xfer_cfg_t         cfg,
  input  logic [comm_pkg::EXT_AW-1:0] ext_mem_offset,
  output logic                        done,
  output comm_pkg::dma_cmd_t          dma_cmd,
  input  logic                        dma_done,
  input  logic                        dma_write_idle,
  input  comm_pkg::beat_t             dma_in,
  output logic                        dma_in_ready,
  output comm_pkg::beat_t             dma_out,
  input  logic                        dma_out_ready,
  input  comm_pkg::beat_t             sock_in,
  output logic                        sock_in_ready,
  output comm_pkg::beat_t             sock_out,
  input  logic                        sock_out_ready
);

  logic go;
  logic store;
  logic lsu_done;
  comm_pkg::beat_t lsu_in;
  logic lsu_in_ready;
  comm_pkg::beat_t lsu_out;
  logic lsu_out_ready;
  comm_pkg::ram_req_t ram_req;
  logic [comm_pkg::DATA_W-1:0] ram_q;

  xfer_ctrl u_ctrl (
    .clk(clk),
    .reset(reset),
    .start(start),
    .cfg(cfg),
    .ext_mem_offset(ext_mem_offset),
    .dma_done(dma_done),
    .dma_write_idle(dma_write_idle),
    .done(done),
    .dma_cmd(dma_cmd),
    .go(go),
    .store(store),
    .dma_in(dma_in),
    .dma_in_ready(dma_in_ready),
    .dma_out(dma_out),
    .dma_out_ready(dma_out_ready),
    .sock_in(sock_in),
    .sock_in_ready(sock_in_ready),
    .sock_out(sock_out),
    .sock_out_ready(sock_out_ready),
    .lsu_in(lsu_in),
    .lsu_in_ready(lsu_in_ready),
    .lsu_out(lsu_out),
    .lsu_out_ready(lsu_out_ready),
    .lsu_done(lsu_done)
  );

  lsu_engine u_lsu (
    .clk(clk),
    .reset(reset),
    .go(go),
    .store(store),
    .cfg(cfg),
    .lsu_in(lsu_in),
    .lsu_in_ready(lsu_in_ready),
    .lsu_out(lsu_out),
    .lsu_out_ready(lsu_out_ready),
    .lsu_done(lsu_done),
    .ram_req(ram_req),
    .ram_q(ram_q)
  );

  scratch_ram u_ram (
    .clk(clk),
    .ram_req(ram_req),
    .ram_q(ram_q)
  );

endmodule

`default_nettype wire

// File: tb/comm_block_sva.sv
`timescale 1ns/1ns
`default_nettype none

module comm_block_sva (
  input logic               clk,
  input logic               reset,
  input logic               done,
  input logic               store,
  input comm_pkg::beat_t    lsu_out,
  input logic               lsu_out_ready,
  input comm_pkg::ram_req_t ram_req
);

  int fail_count = 0;

  done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for two cycles");
    end

  // a stalled beat keeps its data until taken
  out_steady: assert property (@(posedge clk) disable iff (reset)
    lsu_out.valid && !lsu_out_ready |=> lsu_out.valid && $stable(lsu_out.data))
    else begin
      fail_count++;
      $error("stalled store beat changed");
    end

  no_store_write: assert property (@(posedge clk) disable iff (reset)
    store |-> !(ram_req.ce && ram_req.we))
    else begin
      fail_count++;
      $error("RAM written during a store");
    end

endmodule

bind comm_block comm_block_sva u_sva (
  .clk(clk),
  .reset(reset),
  .done(done),
  .store(store),
  .lsu_out(lsu_out),
  .lsu_out_ready(lsu_out_ready),
  .ram_req(ram_req)
);

`default_nettype wire

// File: tb/comm_block_checker.sv
`timescale 1ns/1ns
`default_nettype none

module comm_block_checker (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [8*16-1:0]             test_name,
  input  logic                        start,
  input  comm_pkg::xfer_cfg_t         cfg,
  input  logic [comm_pkg::EXT_AW-1:0] ext_mem_offset,
  input  logic                        done,
  input  comm_pkg::dma_cmd_t          dma_cmd,
  input  logic                        dma_done,
  input  logic                        dma_write_idle,
  input  comm_pkg::beat_t             dma_in,
  input  logic                        dma_in_ready,
  input  comm_pkg::beat_t             dma_out,
  input  logic                        dma_out_ready,
  input  comm_pkg::beat_t             sock_in,
  input  logic                        sock_in_ready,
  input  comm_pkg::beat_t             sock_out,
  input  logic                        sock_out_ready,
  output int                          errors,
  output int                          checks
);

  logic [comm_pkg::DATA_W-1:0] shadow [comm_pkg::RAM_DEPTH];
  comm_pkg::xfer_cfg_t cur;
  logic [comm_pkg::EXT_AW-1:0] exp_addr;
  logic [comm_pkg::RAM_AW-1:0] addr;
  logic [comm_pkg::LEN_W-1:0] beats;
  logic busy, was_busy, cmd_due, dma_seen;
  logic load_sock, load_dma, store_sock, store_dma;
  logic in_fire, out_fire;
  logic [comm_pkg::DATA_W-1:0] in_data, out_data;

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    checks = checks + 1;
    if (act !== exp) begin
      errors = errors + 1;
      $display("[FAIL] %0s: %0s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report(input string what);
    errors = errors + 1;
    $display("ERROR in %0s: %0s", test_name, what);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      busy = 1'b0;
      cmd_due = 1'b0;
      dma_seen = 1'b0;
      errors = 0;
      checks = 0;
    end else begin
      was_busy = busy;
      load_sock = busy & (cur.mode.dir == comm_pkg::DIR_LOAD) & cur.mode.route_socket;
      load_dma = busy & (cur.mode.dir == comm_pkg::DIR_LOAD) & ~cur.mode.route_socket;
      store_sock = busy & (cur.mode.dir == comm_pkg::DIR_STORE) & cur.mode.route_socket;
      store_dma = busy & (cur.mode.dir == comm_pkg::DIR_STORE) & ~cur.mode.route_socket;
      // unselected endpoints stay quiet
      if (dma_in_ready & ~load_dma)
        report("DMA in-stream ready outside a DMA load");
      if (sock_in_ready & ~load_sock)
        report("socket in-stream ready outside a socket load");
      if (dma_out.valid & ~store_dma)
        report("DMA out-stream valid outside a DMA store");
      if (sock_out.valid & ~store_sock)
        report("socket out-stream valid outside a socket store");
      in_fire = (load_sock & sock_in.valid & sock_in_ready) |
                (load_dma & dma_in.valid & dma_in_ready);
      out_fire = (store_sock & sock_out.valid & sock_out_ready) |
                 (store_dma & dma_out.valid & dma_out_ready);
      in_data = cur.mode.route_socket ? sock_in.data : dma_in.data;
      out_data = cur.mode.route_socket ? sock_out.data : dma_out.data;
      if (in_fire | out_fire) begin
        if (beats == cur.len)
          report("beat beyond the transfer length");
        if (in_fire)
          shadow[addr] = in_data;
        else
          check_value("store data", shadow[addr], out_data);
        addr = addr + cur.ram_stride;
        beats = beats + 1'b1;
      end
      if (dma_cmd.start) begin
        if (!cmd_due) begin
          report("DMA command without an honored DMA start");
        end else begin
          check_value("dma ext_addr", exp_addr, dma_cmd.ext_addr);
          check_value("dma len", 64'(cur.len), 64'(dma_cmd.len));
          check_value("dma store", 64'(cur.mode.dir == comm_pkg::DIR_STORE),
                      64'(dma_cmd.store));
        end
      end else if (cmd_due) begin
        report("DMA command missing after a DMA start");
      end
      cmd_due = 1'b0;
      if (busy & dma_done)
        dma_seen = 1'b1;
      if (done) begin
        if (!busy) begin
          report("done pulse with no transfer running");
        end else begin
          check_value("beat count", 64'(cur.len), 64'(beats));
          if (store_dma & ~(dma_seen & dma_write_idle))
            report("DMA store done before dma_done and dma_write_idle");
          busy = 1'b0;
        end
      end
      if (start & ~was_busy &
          (cfg.mode.dir == comm_pkg::DIR_LOAD | cfg.mode.dir == comm_pkg::DIR_STORE)) begin
        cur = cfg;
        exp_addr = cfg.ext_addr + ext_mem_offset;
        addr = cfg.ram_start_idx;
        beats = '0;
        busy = 1'b1;
        dma_seen = 1'b0;
        cmd_due = ~cfg.mode.route_socket;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_comm_block.sv
`timescale 1ns/1ns
`default_nettype none

module tb_comm_block;

  typedef struct packed {
    logic [8*16-1:0]             name;
    comm_pkg::lsu_mode_t         mode;
    logic [comm_pkg::RAM_AW-1:0] idx;
    logic [comm_pkg::RAM_AW-1:0] stride;
    logic [comm_pkg::LEN_W-1:0]  len;
    logic [comm_pkg::EXT_AW-1:0] ext_addr;
    logic                        stall;
    logic [7:0]                  dma_delay;
    logic [comm_pkg::DATA_W-1:0] pattern;
  } test_entry_t;

  logic clk = 1'b0;
  logic reset;
  logic start;
  comm_pkg::xfer_cfg_t cfg;
  logic [comm_pkg::EXT_AW-1:0] ext_mem_offset;
  logic done;
  comm_pkg::dma_cmd_t dma_cmd;
  logic dma_done = 1'b0;
  logic dma_write_idle = 1'b1;
  comm_pkg::beat_t dma_in, dma_out, sock_in, sock_out;
  logic dma_in_ready, sock_in_ready;
  logic dma_out_ready = 1'b0;
  logic sock_out_ready = 1'b0;
  logic [8*16-1:0] test_name;
  int errors, checks;
  int seed = 32'hfd9ad024;
  logic cur_stall = 1'b0;
  logic [7:0] cur_dma_delay = 8'd0;
  int dma_wait = -1;
  int idle_hold = 0;
  logic dma_is_store = 1'b0;
  int cycles = 0;
  int cycle_limit = 0;
  test_entry_t table_q[$];

  always #4 clk = ~clk;

  comm_block dut (.*);

  comm_block_checker u_checker (.*);

  // random back-pressure on both out-streams
  always @(posedge clk) begin
    logic [31:0] rnd;
    #1;
    rnd = $random(seed);
    dma_out_ready = ~cur_stall | rnd[0];
    sock_out_ready = ~cur_stall | rnd[1];
  end

  // DMA engine model with its write side busy for a while after done on stores
  always @(posedge clk) begin
    logic cmd_seen;
    logic cmd_store;
    cmd_seen = dma_cmd.start;
    cmd_store = dma_cmd.store;
    #1;
    dma_done = 1'b0;
    if (cmd_seen) begin
      dma_wait = int'(cur_dma_delay);
      dma_is_store = cmd_store;
    end else if (dma_wait > 0) begin
      dma_wait = dma_wait - 1;
    end else if (dma_wait == 0) begin
      dma_done = 1'b1;
      dma_wait = -1;
      idle_hold = dma_is_store ? 4 : 0;
    end else if (idle_hold > 0) begin
      idle_hold = idle_hold - 1;
    end
    dma_write_idle = ~(dma_is_store & (dma_wait >= 0 || idle_hold > 0));
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run not finished after %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic build_table();
    test_entry_t e;
    e = '{"sock_load_a", '{1'b1, comm_pkg::DIR_LOAD}, 12'd10, 12'd3, 16'd12,
          64'h0, 1'b0, 8'd0, 64'h1111_0000_0000_0000};
    table_q.push_back(e);
    e = '{"sock_store_a", '{1'b1, comm_pkg::DIR_STORE}, 12'd10, 12'd3, 16'd12,
          64'h0, 1'b0, 8'd0, 64'h0};
    table_q.push_back(e);
    e = '{"sock_store_a_bp", '{1'b1, comm_pkg::DIR_STORE}, 12'd10, 12'd3, 16'd12,
          64'h0, 1'b1, 8'd0, 64'h0};
    table_q.push_back(e);
    // wraps the RAM index and the external address
    e = '{"dma_load_b", '{1'b0, comm_pkg::DIR_LOAD}, 12'd4090, 12'd5, 16'd8,
          64'h0000_1000_0000_0000, 1'b0, 8'd2, 64'h2222_0000_0000_00a0};
    table_q.push_back(e);
    e = '{"dma_store_b", '{1'b0, comm_pkg::DIR_STORE}, 12'd4090, 12'd5, 16'd8,
          64'h0000_0000_0123_4560, 1'b1, 8'd2, 64'h0};
    table_q.push_back(e);
    e = '{"bad_dir0", '{1'b1, 2'd0}, 12'd10, 12'd3, 16'd12,
          64'h0, 1'b0, 8'd0, 64'h0};
    table_q.push_back(e);
    e = '{"bad_dir3", '{1'b0, 2'd3}, 12'd4090, 12'd5, 16'd8,
          64'h0000_0000_0000_9000, 1'b0, 8'd2, 64'h0};
    table_q.push_back(e);
    e = '{"dma_store_a_late", '{1'b0, comm_pkg::DIR_STORE}, 12'd10, 12'd3, 16'd12,
          64'hffff_ffff_ffff_ff00, 1'b1, 8'd60, 64'h0};
    table_q.push_back(e);
    e = '{"sock_store_b_bp", '{1'b1, comm_pkg::DIR_STORE}, 12'd4090, 12'd5, 16'd8,
          64'h0, 1'b1, 8'd0, 64'h0};
    table_q.push_back(e);
  endtask

  task automatic run_entry(input test_entry_t e);
    int k;
    logic accepted;
    logic got_done;
    test_name = e.name;
    cur_stall = e.stall;
    cur_dma_delay = e.dma_delay;
    cfg = '{ram_start_idx: e.idx, ram_stride: e.stride, len: e.len,
            ext_addr: e.ext_addr, mode: e.mode};
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (e.mode.dir != comm_pkg::DIR_LOAD && e.mode.dir != comm_pkg::DIR_STORE) begin
      // room for any stray response to an ignored start
      repeat (10) @(posedge clk);
    end else begin
      if (e.mode.dir == comm_pkg::DIR_LOAD) begin
        k = 0;
        while (k < int'(e.len)) begin
          // the other endpoint offers junk that must never be taken
          if (e.mode.route_socket) begin
            sock_in = '{data: 64'(k) + e.pattern, valid: 1'b1};
            dma_in = '{data: ~e.pattern, valid: 1'b1};
          end else begin
            dma_in = '{data: 64'(k) + e.pattern, valid: 1'b1};
            sock_in = '{data: ~e.pattern, valid: 1'b1};
          end
          @(posedge clk);
          accepted = e.mode.route_socket ? sock_in_ready : dma_in_ready;
          #1;
          if (accepted)
            k++;
        end
        sock_in = '0;
        dma_in = '0;
      end else begin
        // in-stream beats offered during a store must never reach the RAM
        sock_in = '{data: ~e.pattern, valid: 1'b1};
        dma_in = '{data: ~e.pattern, valid: 1'b1};
      end
      got_done = 1'b0;
      while (!got_done) begin
        @(posedge clk);
        got_done = done;
      end
    end
    #1;
    sock_in = '0;
    dma_in = '0;
    repeat (2) @(posedge clk);
    #1;
  endtask

  initial begin
    int sva_fails;
    reset = 1'b1;
    start = 1'b0;
    cfg = '0;
    ext_mem_offset = 64'hffff_f000_0000_0400;
    dma_in = '0;
    sock_in = '0;
    test_name = "reset";
    build_table();
    cycle_limit = 200;
    foreach (table_q[i])
      cycle_limit += int'(table_q[i].len) * 4 + 40;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (table_q[i])
      run_entry(table_q[i]);
    repeat (4) @(posedge clk);
    sva_fails = dut.u_sva.fail_count;
    $display("closing: %0d errors, %0d assertion failures, %0d checks",
             errors, sva_fails, checks);
    if (errors == 0 && sva_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: comm_block.f
verilog/comm_pkg.sv
verilog/scratch_ram.sv
verilog/lsu_engine.sv
verilog/xfer_ctrl.sv
verilog/comm_block.sv
tb/comm_block_sva.sv
tb/comm_block_checker.sv
tb/tb_comm_block.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_comm_block
FILELIST  := comm_block.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
